// ==== list.f ====
+incdir+src
src/zstd_frame_pkg.sv
src/zstd_csr_pkg.sv
src/csr_regs.sv
src/dec_ctrl.sv
src/header_reader.sv
src/raw_block_copier.sv
src/mem_read_arb.sv
src/zstd_dec_top.sv
sim/tb_clk_gen.sv
sim/zstd_dec_checker.sv
sim/zstd_dec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= zstd_dec_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed
SOURCES   := list.f $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/zstd_dec_tb.sv ====
`default_nettype none

`include "zstd_dec_macros.svh"

module zstd_dec_tb
  import zstd_frame_pkg::*;
  import zstd_csr_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Memory words read per test, CSR accesses counted as words
  localparam int total_words    = 3 + 6 + 12 + 1 + 5;
  localparam int timeout_cycles = total_words * 12 + 200;

  logic clk;
  logic rst_n;

  logic [`ADDR_W-1:0] csr_awaddr  = '0;
  logic               csr_awvalid = 1'b0;
  logic               csr_awready;
  logic [`DATA_W-1:0] csr_wdata   = '0;
  logic               csr_wvalid  = 1'b0;
  logic               csr_wready;
  logic               csr_bvalid;
  logic               csr_bready  = 1'b0;
  logic [`ADDR_W-1:0] csr_araddr  = '0;
  logic               csr_arvalid = 1'b0;
  logic               csr_arready;
  logic [`DATA_W-1:0] csr_rdata;
  logic               csr_rvalid;
  logic               csr_rready  = 1'b0;

  logic [`ADDR_W-1:0] mem_araddr;
  logic               mem_arvalid;
  logic               mem_arready = 1'b0;
  logic [`DATA_W-1:0] mem_rdata   = '0;
  logic               mem_rvalid  = 1'b0;
  logic               mem_rready;

  logic [`DATA_W-1:0] output_data;
  logic               output_last;
  logic               output_vld;
  logic               output_rdy  = 1'b0;
  logic               notify_vld;
  logic               notify_rdy  = 1'b0;

  logic [`DATA_W-1:0] mem [0:255];
  logic [31:0]        lfsr      = 32'd72;
  logic               rand_rdy  = 1'b0;
  logic               rd_pend   = 1'b0;
  logic [1:0]         wait_cnt  = '0;
  logic [`ADDR_W-1:0] rd_addr   = '0;

  logic [`DATA_W-1:0] exp_q [$];
  logic               last_q [$];
  int rx_idx      = 0;
  int notify_cnt  = 0;
  int mon_err_cnt = 0;
  int chk_err_cnt = 0;
  int cycle_cnt   = 0;
  int err_mark    = 0;
  int test_cnt    = 0;
  int failed_cnt  = 0;

  tb_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  zstd_dec_top i_dut (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .csr_axi_aw_awaddr     (csr_awaddr),
    .csr_axi_aw_awvalid    (csr_awvalid),
    .csr_axi_aw_awready    (csr_awready),
    .csr_axi_w_wdata       (csr_wdata),
    .csr_axi_w_wvalid      (csr_wvalid),
    .csr_axi_w_wready      (csr_wready),
    .csr_axi_b_bvalid      (csr_bvalid),
    .csr_axi_b_bready      (csr_bready),
    .csr_axi_ar_araddr     (csr_araddr),
    .csr_axi_ar_arvalid    (csr_arvalid),
    .csr_axi_ar_arready    (csr_arready),
    .csr_axi_r_rdata       (csr_rdata),
    .csr_axi_r_rvalid      (csr_rvalid),
    .csr_axi_r_rready      (csr_rready),
    .memory_axi_ar_araddr  (mem_araddr),
    .memory_axi_ar_arvalid (mem_arvalid),
    .memory_axi_ar_arready (mem_arready),
    .memory_axi_r_rdata    (mem_rdata),
    .memory_axi_r_rvalid   (mem_rvalid),
    .memory_axi_r_rready   (mem_rready),
    .output_data           (output_data),
    .output_last           (output_last),
    .output_vld            (output_vld),
    .output_rdy            (output_rdy),
    .notify_vld            (notify_vld),
    .notify_rdy            (notify_rdy)
  );

  bind zstd_dec_top zstd_dec_checker i_checker (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .output_data           (output_data),
    .output_last           (output_last),
    .output_vld            (output_vld),
    .output_rdy            (output_rdy),
    .notify_vld            (notify_vld),
    .memory_axi_ar_araddr  (memory_axi_ar_araddr),
    .memory_axi_ar_arvalid (memory_axi_ar_arvalid),
    .memory_axi_ar_arready (memory_axi_ar_arready),
    .csr_axi_b_bvalid      (csr_axi_b_bvalid),
    .csr_axi_r_rvalid      (csr_axi_r_rvalid)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic take_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic int total_errs();
    return mon_err_cnt + chk_err_cnt + i_dut.i_checker.fail_cnt;
  endfunction

  // Memory model with random arready and 0 to 3 extra cycles of read latency, plus output_rdy
  always @(posedge clk) begin : mem_model
    logic [1:0] dly;
    if (!rst_n) begin
      mem_arready <= 1'b0;
      mem_rvalid  <= 1'b0;
      rd_pend     <= 1'b0;
      output_rdy  <= 1'b0;
    end else begin
      output_rdy <= rand_rdy ? take_bit() : 1'b1;
      if (!rd_pend) begin
        if (mem_arvalid && mem_arready) begin
          dly[1] = take_bit();
          dly[0] = take_bit();
          mem_arready <= 1'b0;
          rd_pend     <= 1'b1;
          rd_addr     <= mem_araddr;
          wait_cnt    <= dly;
        end else begin
          mem_arready <= take_bit();
        end
      end else if (!mem_rvalid) begin
        if (wait_cnt == 2'd0) begin
          mem_rvalid <= 1'b1;
          mem_rdata  <= mem[rd_addr[9:2]];
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end else if (mem_rready) begin
        mem_rvalid <= 1'b0;
        rd_pend    <= 1'b0;
      end
    end
  end

  // Scoreboard for the output stream and notify
  always @(posedge clk) begin
    if (rst_n) begin
      if (output_vld && output_rdy) begin
        assert (rx_idx < exp_q.size()) else begin
          $display("unexpected output word %h at %0t ns", output_data, $time);
          mon_err_cnt++;
        end
        if (rx_idx < exp_q.size()) begin
          assert (output_data == exp_q[rx_idx]) else begin
            $display("ERR %0t output_data: got %h, expected %h",
                     $time, output_data, exp_q[rx_idx]);
            mon_err_cnt++;
          end
          assert (output_last == last_q[rx_idx]) else begin
            $display("ERR %0t output_last: got %b, expected %b",
                     $time, output_last, last_q[rx_idx]);
            mon_err_cnt++;
          end
        end
        rx_idx <= rx_idx + 1;
      end
      if (notify_vld && notify_rdy) begin
        notify_cnt <= notify_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout after %0d cycles, the decoder stopped making progress", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
      chk_err_cnt++;
    end
  endtask

  task automatic csr_write(input logic [15:0] addr, input logic [31:0] data);
    @(posedge clk);
    csr_awaddr  <= addr;
    csr_awvalid <= 1'b1;
    csr_wdata   <= data;
    csr_wvalid  <= 1'b1;
    @(posedge clk);
    while (!csr_awready && !csr_wready) @(posedge clk);
    assert (csr_awready && csr_wready) else begin
      $display("awready and wready did not rise together at %0t ns", $time);
      chk_err_cnt++;
    end
    csr_awvalid <= 1'b0;
    csr_wvalid  <= 1'b0;
    csr_bready  <= 1'b1;
    @(posedge clk);
    while (!csr_bvalid) @(posedge clk);
    csr_bready <= 1'b0;
  endtask

  task automatic csr_read(input logic [15:0] addr, output logic [31:0] data);
    @(posedge clk);
    csr_araddr  <= addr;
    csr_arvalid <= 1'b1;
    @(posedge clk);
    while (!csr_arready) @(posedge clk);
    csr_arvalid <= 1'b0;
    csr_rready  <= 1'b1;
    @(posedge clk);
    while (!csr_rvalid) @(posedge clk);
    data = csr_rdata;
    csr_rready <= 1'b0;
  endtask

  // Header word plus payload; raw payload goes on the expected queue
  task automatic put_block(inout int idx, input int size, input block_type_e bt,
                           input logic last);
    mem_word_u w;
    w.hdr.rsvd  = '0;
    w.hdr.size  = 21'(size);
    w.hdr.btype = bt;
    w.hdr.last  = last;
    mem[idx] = w.data;
    idx++;
    for (int k = 0; k < size; k++) begin
      mem[idx] = 32'hd7000000 + (idx * 32'h00010003);
      if (bt == blk_raw) begin
        exp_q.push_back(mem[idx]);
        last_q.push_back(last && (k == size - 1));
      end
      idx++;
    end
  endtask

  task automatic run_frame(input logic [15:0] base, input logic err_magic,
                           input logic err_block);
    int n0;
    logic [31:0] rd;
    status_t exp_st;
    exp_st.busy      = 1'b0;
    exp_st.err_magic = err_magic;
    exp_st.err_block = err_block;
    n0 = notify_cnt;
    csr_write(`CSR_ADDR, {16'h0000, base});
    csr_write(`CSR_CTRL, 32'h1);
    while (notify_cnt == n0) @(posedge clk);
    repeat (5) @(posedge clk);
    assert (notify_cnt == n0 + 1) else begin
      $display("notify fired %0d times for one frame", notify_cnt - n0);
      chk_err_cnt++;
    end
    assert (rx_idx == exp_q.size()) else begin
      $display("output word count is %0d, expected %0d", rx_idx, exp_q.size());
      chk_err_cnt++;
    end
    csr_read(`CSR_STATUS, rd);
    check_val("csr_r_rdata (status)", rd, 32'(exp_st));
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errs() - err_mark;
    test_cnt++;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      failed_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, errs);
    end
    err_mark = total_errs();
  endtask

  initial begin : tests
    int idx;
    logic [31:0] rd;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5a5a0000 ^ (i * 32'h00010001);
    end
    wait (rst_n === 1'b1);
    @(posedge clk);
    notify_rdy <= 1'b1;

    csr_read(`CSR_STATUS, rd);
    check_val("csr_r_rdata (status)", rd, 32'h0);
    csr_write(`CSR_ADDR, 32'h0000_3c40);
    csr_read(`CSR_ADDR, rd);
    check_val("csr_r_rdata (addr)", rd, 32'h0000_3c40);
    end_test("csr readback");

    idx = 16;
    mem[idx] = `ZSTD_MAGIC;
    idx++;
    put_block(idx, 4, blk_raw, 1'b1);
    run_frame(16'h0040, 1'b0, 1'b0);
    end_test("single raw block");

    idx = 64;
    mem[idx] = `ZSTD_MAGIC;
    idx++;
    put_block(idx, 3, blk_raw, 1'b0);
    put_block(idx, 0, blk_raw, 1'b0);
    put_block(idx, 5, blk_raw, 1'b1);
    rand_rdy <= 1'b1;
    run_frame(16'h0100, 1'b0, 1'b0);
    rand_rdy <= 1'b0;
    end_test("three raw blocks with back-pressure");

    mem[128] = `ZSTD_MAGIC ^ 32'h0000_0100;
    run_frame(16'h0200, 1'b1, 1'b0);
    end_test("wrong magic");

    idx = 160;
    mem[idx] = `ZSTD_MAGIC;
    idx++;
    put_block(idx, 2, blk_raw, 1'b0);
    put_block(idx, 3, blk_rle, 1'b0);
    run_frame(16'h0280, 1'b0, 1'b1);
    end_test("rle block after raw");

    $display("%0d tests, %0d failing, %0d errors", test_cnt, failed_cnt, total_errs());
    if (failed_cnt == 0 && total_errs() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/zstd_dec_checker.sv ====
`default_nettype none

`include "zstd_dec_macros.svh"

module zstd_dec_checker (
  input logic               clk,
  input logic               rst_n,
  input logic [`DATA_W-1:0] output_data,
  input logic               output_last,
  input logic               output_vld,
  input logic               output_rdy,
  input logic               notify_vld,
  input logic [`ADDR_W-1:0] memory_axi_ar_araddr,
  input logic               memory_axi_ar_arvalid,
  input logic               memory_axi_ar_arready,
  input logic               csr_axi_b_bvalid,
  input logic               csr_axi_r_rvalid
);

  timeunit 1ns;
  timeprecision 100ps;

  int rst_fail   = 0;
  int hold_fail  = 0;
  int ar_fail    = 0;
  int align_fail = 0;
  int fail_cnt;

  assign fail_cnt = rst_fail + hold_fail + ar_fail + align_fail;

  valid_low_in_reset: assert property (@(posedge clk)
    !rst_n |=> !output_vld && !notify_vld && !memory_axi_ar_arvalid &&
               !csr_axi_b_bvalid && !csr_axi_r_rvalid)
    else begin
      $error("a valid output is high during reset");
      rst_fail++;
    end

  // Stalled beat must not change
  output_hold: assert property (@(posedge clk) disable iff (!rst_n)
    output_vld && !output_rdy |=>
      output_vld && $stable(output_data) && $stable(output_last))
    else begin
      $error("output stream changed while stalled");
      hold_fail++;
    end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    memory_axi_ar_arvalid && !memory_axi_ar_arready |=>
      memory_axi_ar_arvalid && $stable(memory_axi_ar_araddr))
    else begin
      $error("memory read request dropped or changed before arready");
      ar_fail++;
    end

  ar_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    memory_axi_ar_arvalid |-> memory_axi_ar_araddr[1:0] == 2'b00)
    else begin
      $error("memory read address is not word-aligned");
      align_fail++;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  logic rst_q = 1'b0;

  assign rst_n = rst_q;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (10) @(posedge clk);
    rst_q <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== src/zstd_dec_top.sv ====
`default_nettype none

`include "zstd_dec_macros.svh"

module zstd_dec_top
  import zstd_frame_pkg::*;
  import zstd_csr_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [`ADDR_W-1:0] csr_axi_aw_awaddr,
  input  logic               csr_axi_aw_awvalid,
  output logic               csr_axi_aw_awready,
  input  logic [`DATA_W-1:0] csr_axi_w_wdata,
  input  logic               csr_axi_w_wvalid,
  output logic               csr_axi_w_wready,
  output logic               csr_axi_b_bvalid,
  input  logic               csr_axi_b_bready,
  input  logic [`ADDR_W-1:0] csr_axi_ar_araddr,
  input  logic               csr_axi_ar_arvalid,
  output logic               csr_axi_ar_arready,
  output logic [`DATA_W-1:0] csr_axi_r_rdata,
  output logic               csr_axi_r_rvalid,
  input  logic               csr_axi_r_rready,
  output logic [`ADDR_W-1:0] memory_axi_ar_araddr,
  output logic               memory_axi_ar_arvalid,
  input  logic               memory_axi_ar_arready,
  input  logic [`DATA_W-1:0] memory_axi_r_rdata,
  input  logic               memory_axi_r_rvalid,
  output logic               memory_axi_r_rready,
  output logic [`DATA_W-1:0] output_data,
  output logic               output_last,
  output logic               output_vld,
  input  logic               output_rdy,
  output logic               notify_vld,
  input  logic               notify_rdy
);

  logic               start;
  logic [`ADDR_W-1:0] base_addr;
  status_t            status;

  logic               hdr_req;
  logic [`ADDR_W-1:0] hdr_addr;
  logic               hdr_done;
  logic               magic_ok;
  block_header_t      blk_hdr;

  logic               copy_req;
  logic [`ADDR_W-1:0] copy_addr;
  logic [20:0]        copy_words;
  logic               copy_final;
  logic               copy_done;

  // Reader sides of the memory arbiter
  logic               hdr_arvalid;
  logic [`ADDR_W-1:0] hdr_araddr;
  logic               hdr_arready;
  logic [`DATA_W-1:0] hdr_rdata;
  logic               hdr_rvalid;
  logic               hdr_rready;
  logic               copy_arvalid;
  logic [`ADDR_W-1:0] copy_araddr;
  logic               copy_arready;
  logic [`DATA_W-1:0] copy_rdata;
  logic               copy_rvalid;
  logic               copy_rready;

  csr_regs i_csr_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (csr_axi_aw_awaddr),
    .awvalid   (csr_axi_aw_awvalid),
    .awready   (csr_axi_aw_awready),
    .wdata     (csr_axi_w_wdata),
    .wvalid    (csr_axi_w_wvalid),
    .wready    (csr_axi_w_wready),
    .bvalid    (csr_axi_b_bvalid),
    .bready    (csr_axi_b_bready),
    .araddr    (csr_axi_ar_araddr),
    .arvalid   (csr_axi_ar_arvalid),
    .arready   (csr_axi_ar_arready),
    .rdata     (csr_axi_r_rdata),
    .rvalid    (csr_axi_r_rvalid),
    .rready    (csr_axi_r_rready),
    .status    (status),
    .start     (start),
    .base_addr (base_addr)
  );

  dec_ctrl i_dec_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .base_addr  (base_addr),
    .hdr_req    (hdr_req),
    .hdr_addr   (hdr_addr),
    .hdr_done   (hdr_done),
    .magic_ok   (magic_ok),
    .blk_hdr    (blk_hdr),
    .copy_req   (copy_req),
    .copy_addr  (copy_addr),
    .copy_words (copy_words),
    .copy_final (copy_final),
    .copy_done  (copy_done),
    .status     (status),
    .notify_vld (notify_vld),
    .notify_rdy (notify_rdy)
  );

  header_reader i_header_reader (
    .clk      (clk),
    .rst_n    (rst_n),
    .hdr_req  (hdr_req),
    .hdr_addr (hdr_addr),
    .hdr_done (hdr_done),
    .magic_ok (magic_ok),
    .blk_hdr  (blk_hdr),
    .arvalid  (hdr_arvalid),
    .araddr   (hdr_araddr),
    .arready  (hdr_arready),
    .rdata    (hdr_rdata),
    .rvalid   (hdr_rvalid),
    .rready   (hdr_rready)
  );

  raw_block_copier i_raw_block_copier (
    .clk         (clk),
    .rst_n       (rst_n),
    .copy_req    (copy_req),
    .copy_addr   (copy_addr),
    .copy_words  (copy_words),
    .copy_final  (copy_final),
    .copy_done   (copy_done),
    .arvalid     (copy_arvalid),
    .araddr      (copy_araddr),
    .arready     (copy_arready),
    .rdata       (copy_rdata),
    .rvalid      (copy_rvalid),
    .rready      (copy_rready),
    .output_data (output_data),
    .output_vld  (output_vld),
    .output_rdy  (output_rdy),
    .output_last (output_last)
  );

  mem_read_arb i_mem_read_arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .hdr_arvalid  (hdr_arvalid),
    .hdr_araddr   (hdr_araddr),
    .hdr_arready  (hdr_arready),
    .hdr_rdata    (hdr_rdata),
    .hdr_rvalid   (hdr_rvalid),
    .hdr_rready   (hdr_rready),
    .copy_arvalid (copy_arvalid),
    .copy_araddr  (copy_araddr),
    .copy_arready (copy_arready),
    .copy_rdata   (copy_rdata),
    .copy_rvalid  (copy_rvalid),
    .copy_rready  (copy_rready),
    .mem_arvalid  (memory_axi_ar_arvalid),
    .mem_araddr   (memory_axi_ar_araddr),
    .mem_arready  (memory_axi_ar_arready),
    .mem_rdata    (memory_axi_r_rdata),
    .mem_rvalid   (memory_axi_r_rvalid),
    .mem_rready   (memory_axi_r_rready)
  );

endmodule

`default_nettype wire

// ==== src/mem_read_arb.sv ====
`default_nettype none

`include "zstd_dec_macros.svh"

module mem_read_arb (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               hdr_arvalid,
  input  logic [`ADDR_W-1:0] hdr_araddr,
  output logic               hdr_arready,
  output logic [`DATA_W-1:0] hdr_rdata,
  output logic               hdr_rvalid,
  input  logic               hdr_rready,
  input  logic               copy_arvalid,
  input  logic [`ADDR_W-1:0] copy_araddr,
  output logic               copy_arready,
  output logic [`DATA_W-1:0] copy_rdata,
  output logic               copy_rvalid,
  input  logic               copy_rready,
  output logic               mem_arvalid,
  output logic [`ADDR_W-1:0] mem_araddr,
  input  logic               mem_arready,
  input  logic [`DATA_W-1:0] mem_rdata,
  input  logic               mem_rvalid,
  output logic               mem_rready
);

  logic busy_q;
  logic own_copy;
  logic sel_copy;

  // Header reads win, grant decided in the request cycle
  assign sel_copy     = !hdr_arvalid;
  assign mem_arvalid  = !busy_q && (hdr_arvalid || copy_arvalid);
  assign mem_araddr   = sel_copy ? copy_araddr : hdr_araddr;
  assign hdr_arready  = !busy_q && mem_arready;
  assign copy_arready = !busy_q && mem_arready && !hdr_arvalid;

  // Response goes back to the owner of the outstanding read
  assign hdr_rdata   = mem_rdata;
  assign copy_rdata  = mem_rdata;
  assign hdr_rvalid  = busy_q && !own_copy && mem_rvalid;
  assign copy_rvalid = busy_q && own_copy && mem_rvalid;
  assign mem_rready  = busy_q && (own_copy ? copy_rready : hdr_rready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      own_copy <= 1'b0;
    end else if (mem_arvalid && mem_arready) begin
      busy_q   <= 1'b1;
      own_copy <= sel_copy;
    end else if (mem_rvalid && mem_rready) begin
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/raw_block_copier.sv ====
`default_nettype none

`include "zstd_dec_macros.svh"

module raw_block_copier (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               copy_req,
  input  logic [`ADDR_W-1:0] copy_addr,
  input  logic [20:0]        copy_words,
  input  logic               copy_final,
  output logic               copy_done,
  output logic               arvalid,
  output logic [`ADDR_W-1:0] araddr,
  input  logic               arready,
  input  logic [`DATA_W-1:0] rdata,
  input  logic               rvalid,
  output logic               rready,
  output logic [`DATA_W-1:0] output_data,
  output logic               output_vld,
  input  logic               output_rdy,
  output logic               output_last
);

  localparam logic [2:0] s_idle = 3'd0;
  localparam logic [2:0] s_ar   = 3'd1;
  localparam logic [2:0] s_r    = 3'd2;
  localparam logic [2:0] s_out  = 3'd3;
  localparam logic [2:0] s_done = 3'd4;

  logic [2:0]         state;
  logic [`ADDR_W-1:0] addr_q;
  logic [20:0]        remain;
  logic [`DATA_W-1:0] data_q;

  assign arvalid     = (state == s_ar);
  assign araddr      = addr_q;
  assign rready      = (state == s_r);
  assign output_vld  = (state == s_out);
  assign output_data = data_q;
  // Only the final word of the final block
  assign output_last = output_vld && copy_final && (remain == 21'd1);
  assign copy_done   = (state == s_done);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= s_idle;
      addr_q <= '0;
      remain <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (copy_req) begin
            addr_q <= copy_addr;
            remain <= copy_words;
            // Empty block finishes without a read
            state  <= (copy_words == '0) ? s_done : s_ar;
          end
        end
        s_ar: begin
          if (arready) begin
            state <= s_r;
          end
        end
        s_r: begin
          if (rvalid) begin
            state <= s_out;
          end
        end
        s_out: begin
          if (output_rdy) begin
            addr_q <= addr_q + `ADDR_W'd4;
            remain <= remain - 21'd1;
            state  <= (remain == 21'd1) ? s_done : s_ar;
          end
        end
        s_done:  state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == s_r) && rvalid) begin
      data_q <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== src/header_reader.sv ====
`default_nettype none

`include "zstd_dec_macros.svh"

module header_reader
  import zstd_frame_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               hdr_req,
  input  logic [`ADDR_W-1:0] hdr_addr,
  output logic               hdr_done,
  output logic               magic_ok,
  output block_header_t      blk_hdr,
  output logic               arvalid,
  output logic [`ADDR_W-1:0] araddr,
  input  logic               arready,
  input  logic [`DATA_W-1:0] rdata,
  input  logic               rvalid,
  output logic               rready
);

  logic      rd_wait;
  logic      done_q;
  logic      r_fire;
  mem_word_u word_q;

  // No new read in the done cycle, the requester still holds hdr_req
  assign arvalid  = hdr_req && !rd_wait && !done_q;
  assign araddr   = hdr_addr;
  assign rready   = rd_wait;
  assign r_fire   = rvalid && rd_wait;
  assign hdr_done = done_q;

  // Both views of the last fetched word
  assign magic_ok = (word_q.data == `ZSTD_MAGIC);
  assign blk_hdr  = word_q.hdr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_wait <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= r_fire;
      if (arvalid && arready) begin
        rd_wait <= 1'b1;
      end else if (r_fire) begin
        rd_wait <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (r_fire) begin
      word_q.data <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== src/dec_ctrl.sv ====
`default_nettype none

`include "zstd_dec_macros.svh"

module dec_ctrl
  import zstd_frame_pkg::*;
  import zstd_csr_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic [`ADDR_W-1:0] base_addr,
  output logic               hdr_req,
  output logic [`ADDR_W-1:0] hdr_addr,
  input  logic               hdr_done,
  input  logic               magic_ok,
  input  block_header_t      blk_hdr,
  output logic               copy_req,
  output logic [`ADDR_W-1:0] copy_addr,
  output logic [20:0]        copy_words,
  output logic               copy_final,
  input  logic               copy_done,
  output status_t            status,
  output logic               notify_vld,
  input  logic               notify_rdy
);

  localparam logic [2:0] s_idle   = 3'd0;
  localparam logic [2:0] s_magic  = 3'd1;
  localparam logic [2:0] s_header = 3'd2;
  localparam logic [2:0] s_copy   = 3'd3;
  localparam logic [2:0] s_notify = 3'd4;

  logic [2:0]         state;
  logic [`ADDR_W-1:0] ptr;

  assign hdr_req    = (state == s_magic) || (state == s_header);
  assign hdr_addr   = ptr;
  assign copy_req   = (state == s_copy);
  assign copy_addr  = ptr;
  // Header word stays registered in the reader for the whole copy
  assign copy_words = blk_hdr.size;
  assign copy_final = blk_hdr.last;
  assign notify_vld = (state == s_notify);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= s_idle;
      ptr    <= '0;
      status <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (start) begin
            state  <= s_magic;
            ptr    <= base_addr;
            status <= '{busy: 1'b1, err_magic: 1'b0, err_block: 1'b0};
          end
        end
        s_magic: begin
          if (hdr_done) begin
            ptr <= ptr + `ADDR_W'd4;
            if (magic_ok) begin
              state <= s_header;
            end else begin
              status.err_magic <= 1'b1;
              state            <= s_notify;
            end
          end
        end
        s_header: begin
          if (hdr_done) begin
            ptr <= ptr + `ADDR_W'd4;
            if (blk_hdr.btype == blk_raw) begin
              state <= s_copy;
            end else begin
              status.err_block <= 1'b1;
              state            <= s_notify;
            end
          end
        end
        s_copy: begin
          if (copy_done) begin
            // Skip over the block payload
            ptr   <= ptr + {blk_hdr.size[`ADDR_W-3:0], 2'b00};
            state <= blk_hdr.last ? s_notify : s_header;
          end
        end
        s_notify: begin
          if (notify_rdy) begin
            status.busy <= 1'b0;
            state       <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/csr_regs.sv ====
`default_nettype none

`include "zstd_dec_macros.svh"

module csr_regs
  import zstd_csr_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [`ADDR_W-1:0] awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  logic [`DATA_W-1:0] wdata,
  input  logic               wvalid,
  output logic               wready,
  output logic               bvalid,
  input  logic               bready,
  input  logic [`ADDR_W-1:0] araddr,
  input  logic               arvalid,
  output logic               arready,
  output logic [`DATA_W-1:0] rdata,
  output logic               rvalid,
  input  logic               rready,
  input  status_t            status,
  output logic               start,
  output logic [`ADDR_W-1:0] base_addr
);

  logic wr_fire;
  logic rd_fire;
  logic start_wr;

  // Address and data beats are taken together
  assign awready  = awvalid && wvalid && !bvalid;
  assign wready   = awready;
  assign wr_fire  = awready;
  assign start_wr = wr_fire && (awaddr == `CSR_CTRL) && wdata[ctrl_start_bit];

  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid    <= 1'b0;
      start     <= 1'b0;
      base_addr <= '0;
    end else begin
      // Ignored while a frame is running
      start <= start_wr && !status.busy;
      if (wr_fire && (awaddr == `CSR_ADDR)) begin
        base_addr <= wdata[`ADDR_W-1:0];
      end
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (araddr)
        `CSR_ADDR:   rdata <= {{(`DATA_W - `ADDR_W){1'b0}}, base_addr};
        `CSR_STATUS: rdata <= {{(`DATA_W - $bits(status_t)){1'b0}}, status};
        default:     rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/zstd_csr_pkg.sv ====
`default_nettype none

package zstd_csr_pkg;

  // Start command bit in CSR_CTRL
  localparam int ctrl_start_bit = 0;

  // Read back zero-extended from CSR_STATUS
  typedef struct packed {
    logic busy;
    logic err_magic;
    logic err_block;
  } status_t;

endpackage

`default_nettype wire

// ==== src/zstd_frame_pkg.sv ====
`default_nettype none

`include "zstd_dec_macros.svh"

package zstd_frame_pkg;

  typedef enum logic [1:0] {
    blk_raw        = 2'd0,
    blk_rle        = 2'd1,
    blk_compressed = 2'd2,
    blk_reserved   = 2'd3
  } block_type_e;

  // Size counts 32-bit words in this format
  typedef struct packed {
    logic [7:0]  rsvd;
    logic [20:0] size;
    block_type_e btype;
    logic        last;
  } block_header_t;

  // One memory word, read either as a header or as payload
  typedef union packed {
    block_header_t      hdr;
    logic [`DATA_W-1:0] data;
  } mem_word_u;

endpackage

`default_nettype wire

// ==== src/zstd_dec_macros.svh ====
`ifndef ZSTD_DEC_MACROS_SVH
`define ZSTD_DEC_MACROS_SVH

// Bus widths
`define DATA_W 32
`define ADDR_W 16

// Frame magic as one little-endian memory word
`define ZSTD_MAGIC 32'hfd2fb528

// Register byte offsets
`define CSR_CTRL   16'h0000
`define CSR_ADDR   16'h0004
`define CSR_STATUS 16'h0008

`endif
